// File: verilog.f
+incdir+include
logic/codec_pkg.sv
logic/codec_reg_rom.sv
logic/i2c_write_engine.sv
logic/codec_init_seq.sv
logic/codec_init_top.sv
tests/i2c_codec_model.sv
tests/tb_codec_init.sv

// File: Bender.yml
package:
  name: codec_init

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/codec_pkg.sv
      - logic/codec_reg_rom.sv
      - logic/i2c_write_engine.sv
      - logic/codec_init_seq.sv
      - logic/codec_init_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/i2c_codec_model.sv
      - tests/tb_codec_init.sv

// File: tests/tb_codec_init.sv
`timescale 1ns/100ps
`include "codec_cfg.svh"

module tb_codec_init;

    localparam int FRAME_CYC    = 2 + (27 + 2) * 4 * `CFG_I2C_QTR;
    localparam int WATCHDOG_CYC = 4 * `CFG_NUM_REGS * (FRAME_CYC + 4) + 3000;
    localparam logic [7:0] ADDR_BYTE = {7'h1A, 1'b0};    // Codec address with the write bit

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    codec_pkg::init_status_t    status;
    logic                       scl;
    logic                       sda_out;
    logic                       sda_oe;
    logic                       sda_pull;
    logic                       sda;
    logic                       refuse_en;
    int                         refuse_frame;
    int                         refuse_byte;

    codec_pkg::reg_write_t      expected [`CFG_NUM_REGS];
    int                         stops;
    logic                       bus_in_frame;
    logic                       scl_prev;
    logic                       sda_prev;
    int                         seed_ret;
    int                         base;
    int                         k;

    assign sda = (sda_oe ? sda_out : 1'b1) & ~sda_pull;    // Open-drain resolution

    codec_init_top u_codec_init_top (
        .i_clk(clk),
        .i_rst_n(rst_n),
        .i_start(start),
        .o_status(status),
        .o_scl(scl),
        .o_sda_out(sda_out),
        .o_sda_oe(sda_oe),
        .i_sda(sda)
    );

    i2c_codec_model u_codec_model (
        .i_clk(clk),
        .i_scl(scl),
        .i_sda(sda),
        .i_refuse_en(refuse_en),
        .i_refuse_frame(refuse_frame),
        .i_refuse_byte(refuse_byte),
        .o_sda_pull(sda_pull)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2 start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
    endtask

    task automatic wait_finished();
        do begin
            @(posedge clk);
        end while (!status.finished);
    endtask

    // Frames from first onward against the start of the table
    task automatic check_payloads(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            assert (u_codec_model.addr_bytes[first+i] == ADDR_BYTE)
            else report_failure($sformatf("frame %0d address byte %h",
                                          i, u_codec_model.addr_bytes[first+i]));
            assert (u_codec_model.frames[first+i] == expected[i])
            else report_failure($sformatf("frame %0d payload %h, expected %h",
                                          i, u_codec_model.frames[first+i], expected[i]));
        end
    endtask

    task automatic run_full_sequence(input logic poke_mid_run);
        base = u_codec_model.frames.size();
        pulse_start();
        assert (status == '0) else report_failure("start did not clear the status");
        if (poke_mid_run) begin
            repeat ($urandom_range(20, 3 * FRAME_CYC)) @(posedge clk);
            pulse_start();                          // Ignored while busy
        end
        wait_finished();
        assert (u_codec_model.frames.size() == base + `CFG_NUM_REGS)
        else report_failure($sformatf("%0d frames seen",
                                      u_codec_model.frames.size() - base));
        check_payloads(base, `CFG_NUM_REGS);
        assert (!status.error) else report_failure("error set on an acknowledged run");
        assert (stops == u_codec_model.frames.size())
        else report_failure("stop count differs from frame count");
    endtask

    // SDA may only move with SCL low, apart from start and stop
    always @(posedge clk) begin
        if (!rst_n) begin
            bus_in_frame = 1'b0;
            scl_prev     = 1'b1;
            sda_prev     = 1'b1;
            stops        = 0;
        end else begin
            if (scl_prev && scl && (sda != sda_prev)) begin
                if (!sda) begin
                    assert (!bus_in_frame) else report_failure("start inside a frame");
                    bus_in_frame = 1'b1;
                end else begin
                    assert (bus_in_frame) else report_failure("stop outside a frame");
                    bus_in_frame = 1'b0;
                    stops        = stops + 1;
                end
            end
            assert (!(!scl_prev && scl && (sda != sda_prev)))
            else report_failure("SDA changed as SCL rose");
            scl_prev = scl;
            sda_prev = sda;
        end
    end

    // Status and bus frozen once finished, until the next start
    assert property (@(posedge clk) disable iff (!rst_n)
        (status.finished && !start) |=>
            (status.finished && (status.error == $past(status.error)) && scl && sda))
    else report_failure("status or bus moved after finish without a start");

    assert property (@(posedge clk) disable iff (!rst_n) status.error |-> status.finished)
    else report_failure("error without finished");

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Watchdog expired: the init sequences did not complete in time");
        $display("TB FAILED");
        $fatal(1);
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        refuse_en    = 1'b0;
        refuse_frame = 0;
        refuse_byte  = 0;
        expected[0]  = '{reg_addr: 7'h0F, reg_data: 9'h000};
        expected[1]  = '{reg_addr: 7'h04, reg_data: 9'h015};
        expected[2]  = '{reg_addr: 7'h05, reg_data: 9'h000};
        expected[3]  = '{reg_addr: 7'h06, reg_data: 9'h000};
        expected[4]  = '{reg_addr: 7'h07, reg_data: 9'h042};
        expected[5]  = '{reg_addr: 7'h08, reg_data: 9'h019};
        expected[6]  = '{reg_addr: 7'h09, reg_data: 9'h001};
        seed_ret     = $urandom(32'h25cc83fb);
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;

        repeat ($urandom_range(4, 40)) begin
            @(posedge clk);
            assert (scl && sda && sda_oe && (status == '0))
            else report_failure("bus or status not idle after reset");
        end

        run_full_sequence(1'b1);
        repeat ($urandom_range(10, 100)) @(posedge clk);   // Hold checked by property
        run_full_sequence(1'b0);
        repeat ($urandom_range(10, 100)) @(posedge clk);

        // One refused byte somewhere in the table
        k = $urandom_range(0, `CFG_NUM_REGS - 1);
        #2;
        refuse_frame = u_codec_model.frames.size() + k;
        refuse_byte  = $urandom_range(0, 2);
        refuse_en    = 1'b1;
        base         = u_codec_model.frames.size();
        pulse_start();
        wait_finished();
        assert (status.error) else report_failure("NACK did not set error");
        assert (u_codec_model.frames.size() == base + k + 1)
        else report_failure($sformatf("%0d frames after NACK in write %0d",
                                      u_codec_model.frames.size() - base, k));
        check_payloads(base, k + 1);
        assert (!bus_in_frame && !u_codec_model.in_frame && (stops == base + k + 1))
        else report_failure("refused frame did not end with a stop");
        #2 refuse_en = 1'b0;

        repeat ($urandom_range(10, 100)) @(posedge clk);
        run_full_sequence(1'b0);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: tests/i2c_codec_model.sv
`timescale 1ns/100ps
`include "codec_cfg.svh"

module i2c_codec_model (
    input  logic    i_clk,
    input  logic    i_scl,
    input  logic    i_sda,
    input  logic    i_refuse_en,
    input  int      i_refuse_frame,     // Frame number counted from the first frame seen
    input  int      i_refuse_byte,      // 0 device address, 1 and 2 payload
    output logic    o_sda_pull          // High pulls SDA low
);

    codec_pkg::reg_write_t  frames[$];      // Decoded payloads in bus order
    logic [7:0]             addr_bytes[$];
    logic                   in_frame;

    logic           scl_q;
    logic           sda_q;
    int             bit_cnt;                // 0..7 data, 8 byte done, 9 ack slot
    int             byte_idx;
    logic [7:0]     shift;
    logic [23:0]    bytes;
    logic           refuse;
    logic           wrong_addr;

    initial begin
        in_frame   = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        bit_cnt    = 0;
        byte_idx   = 0;
        shift      = '0;
        bytes      = '0;
        o_sda_pull <= 1'b0;
    end

    // Line sampled on the system clock, so start and stop need SCL high on both samples
    always @(posedge i_clk) begin
        if (scl_q && i_scl && sda_q && !i_sda) begin
            in_frame = 1'b1;                // Start
            bit_cnt  = 0;
            byte_idx = 0;
        end else if (scl_q && i_scl && !sda_q && i_sda) begin
            if (in_frame) begin
                addr_bytes.push_back(bytes[23:16]);
                frames.push_back(codec_pkg::reg_write_t'(bytes[15:0]));
            end
            in_frame   = 1'b0;              // Stop
            o_sda_pull <= 1'b0;
        end else if (in_frame && !scl_q && i_scl) begin
            if (bit_cnt < 8) begin
                shift   = {shift[6:0], i_sda};
                bit_cnt = bit_cnt + 1;
            end
        end else if (in_frame && scl_q && !i_scl) begin
            if (bit_cnt == 8) begin
                if (byte_idx < 3) begin
                    bytes[8*(2-byte_idx) +: 8] = shift;
                end
                refuse     = i_refuse_en && (frames.size() == i_refuse_frame)
                             && (byte_idx == i_refuse_byte);
                wrong_addr = (byte_idx == 0) && (shift != {`CFG_DEV_ADDR, 1'b0});
                o_sda_pull <= !(refuse || wrong_addr);
                bit_cnt    = 9;
            end else if (bit_cnt == 9) begin
                o_sda_pull <= 1'b0;         // Ack slot over
                bit_cnt    = 0;
                byte_idx   = byte_idx + 1;
            end
        end
        scl_q = i_scl;
        sda_q = i_sda;
    end

endmodule

// File: logic/codec_init_top.sv
`timescale 1ns/100ps
`include "codec_cfg.svh"

module codec_init_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    output codec_pkg::init_status_t     o_status,
    output logic                        o_scl,
    output logic                        o_sda_out,
    output logic                        o_sda_oe,
    input  logic                        i_sda
);

    localparam int IDX_W = $clog2(`CFG_NUM_REGS);

    logic [IDX_W-1:0]       index;
    codec_pkg::reg_write_t  write;
    logic                   go;
    logic                   done;
    logic                   nack;
    logic                   busy;

    codec_init_seq #(
        .IDX_W(IDX_W)
    ) u_seq (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_start(i_start),
        .o_index(index),
        .o_go(go),
        .i_done(done),
        .i_nack(nack),
        .i_busy(busy),
        .o_status(o_status)
    );

    codec_reg_rom #(
        .IDX_W(IDX_W)
    ) u_rom (
        .i_index(index),
        .o_write(write)
    );

    i2c_write_engine u_engine (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_go(go),
        .i_write(write),
        .o_done(done),
        .o_nack(nack),
        .o_busy(busy),
        .o_scl(o_scl),
        .o_sda_out(o_sda_out),
        .o_sda_oe(o_sda_oe),
        .i_sda(i_sda)
    );

endmodule

// File: logic/codec_init_seq.sv
`timescale 1ns/100ps
`include "codec_cfg.svh"

module codec_init_seq #(
    parameter int IDX_W = $clog2(`CFG_NUM_REGS)
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    output logic [IDX_W-1:0]            o_index,
    output logic                        o_go,
    input  logic                        i_done,
    input  logic                        i_nack,
    input  logic                        i_busy,
    output codec_pkg::init_status_t     o_status
);

    codec_pkg::seq_state_e      state_r;
    logic [IDX_W-1:0]           idx_r;
    codec_pkg::init_status_t    status_r;
    logic                       last;

    assign last     = (idx_r == IDX_W'(`CFG_NUM_REGS - 1));
    assign o_index  = idx_r;
    assign o_status = status_r;

    // Go goes out in the launch cycle, with the table entry alongside
    assign o_go = (state_r == codec_pkg::SEQ_LAUNCH) && !i_busy;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r  <= codec_pkg::SEQ_IDLE;
            idx_r    <= '0;
            status_r <= '0;
        end else begin
            case (state_r)
                codec_pkg::SEQ_IDLE, codec_pkg::SEQ_DONE: begin
                    if (i_start) begin
                        status_r <= '0;     // Restart clears both flags
                        idx_r    <= '0;
                        state_r  <= codec_pkg::SEQ_LAUNCH;
                    end
                end
                codec_pkg::SEQ_LAUNCH: begin
                    if (!i_busy) begin
                        state_r <= codec_pkg::SEQ_WAIT;
                    end
                end
                codec_pkg::SEQ_WAIT: begin
                    if (i_done) begin
                        if (i_nack) begin
                            // Abort the rest of the table
                            status_r.error    <= 1'b1;
                            status_r.finished <= 1'b1;
                            state_r           <= codec_pkg::SEQ_DONE;
                        end else if (last) begin
                            status_r.finished <= 1'b1;
                            state_r           <= codec_pkg::SEQ_DONE;
                        end else begin
                            idx_r   <= idx_r + IDX_W'(1);
                            state_r <= codec_pkg::SEQ_LAUNCH;
                        end
                    end
                end
                default: begin
                    state_r <= codec_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/i2c_write_engine.sv
`timescale 1ns/100ps
`include "codec_cfg.svh"

module i2c_write_engine (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_go,
    input  codec_pkg::reg_write_t   i_write,
    output logic                    o_done,
    output logic                    o_nack,
    output logic                    o_busy,
    output logic                    o_scl,
    output logic                    o_sda_out,
    output logic                    o_sda_oe,
    input  logic                    i_sda
);

    localparam int QW = (`CFG_I2C_QTR > 1) ? $clog2(`CFG_I2C_QTR) : 1;

    codec_pkg::bit_state_e state_r, state_n;
    logic [QW-1:0]  qcnt_r, qcnt_n;         // Cycles within a quarter
    logic [1:0]     quarter_r, quarter_n;   // Quarter within a bit
    logic [2:0]     bit_r, bit_n;           // Data bit within a byte
    logic [1:0]     byte_r, byte_n;
    logic [23:0]    shift_r, shift_n;
    logic           nack_r, nack_n;
    logic           done_r, done_n;
    logic           scl_r, scl_n;
    logic           sda_r, sda_n;
    logic           oe_r, oe_n;
    logic           tick;

    assign tick      = (qcnt_r == QW'(`CFG_I2C_QTR - 1));
    assign o_done    = done_r;
    assign o_nack    = nack_r;
    assign o_busy    = (state_r != codec_pkg::BIT_IDLE);
    assign o_scl     = scl_r;
    assign o_sda_out = sda_r;
    assign o_sda_oe  = oe_r;

    // Sequencing of quarters, bits and bytes
    always_comb begin
        state_n   = state_r;
        qcnt_n    = qcnt_r;
        quarter_n = quarter_r;
        bit_n     = bit_r;
        byte_n    = byte_r;
        shift_n   = shift_r;
        nack_n    = nack_r;
        done_n    = 1'b0;
        case (state_r)
            codec_pkg::BIT_IDLE: begin
                if (i_go) begin
                    state_n   = codec_pkg::BIT_START;
                    qcnt_n    = '0;
                    quarter_n = 2'd0;
                    bit_n     = 3'd0;
                    byte_n    = 2'd0;
                    shift_n   = {`CFG_DEV_ADDR, 1'b0, i_write.reg_addr, i_write.reg_data};
                    nack_n    = 1'b0;
                end
            end
            codec_pkg::BIT_DONE: begin
                done_n  = 1'b1;
                state_n = codec_pkg::BIT_IDLE;
            end
            default: begin
                if (!tick) begin
                    qcnt_n = qcnt_r + QW'(1);
                end else begin
                    qcnt_n    = '0;
                    quarter_n = quarter_r + 2'd1;
                    // Ack sampled entering the second high quarter
                    if (state_r == codec_pkg::BIT_ACK && quarter_r == 2'd2) begin
                        nack_n = nack_r | i_sda;
                    end
                    if (quarter_r == 2'd3) begin
                        case (state_r)
                            codec_pkg::BIT_START: begin
                                state_n = codec_pkg::BIT_DATA;
                                bit_n   = 3'd0;
                            end
                            codec_pkg::BIT_DATA: begin
                                shift_n = {shift_r[22:0], 1'b0};
                                bit_n   = bit_r + 3'd1;
                                if (bit_r == 3'd7) begin
                                    state_n = codec_pkg::BIT_ACK;
                                end
                            end
                            codec_pkg::BIT_ACK: begin
                                if (byte_r == 2'd2) begin
                                    state_n = codec_pkg::BIT_STOP;
                                end else begin
                                    state_n = codec_pkg::BIT_DATA;
                                    byte_n  = byte_r + 2'd1;
                                    bit_n   = 3'd0;
                                end
                            end
                            default: begin
                                state_n = codec_pkg::BIT_DONE;     // End of stop bit
                            end
                        endcase
                    end
                end
            end
        endcase
    end

    // Pin levels for the coming cycle, SCL low in quarters 0 and 1
    always_comb begin
        scl_n = 1'b1;
        sda_n = 1'b1;
        oe_n  = 1'b1;
        case (state_n)
            codec_pkg::BIT_START: begin
                scl_n = (quarter_n != 2'd3);
                sda_n = (quarter_n < 2'd2);     // Falls with SCL high
            end
            codec_pkg::BIT_DATA: begin
                scl_n = quarter_n[1];
                sda_n = shift_n[23];
            end
            codec_pkg::BIT_ACK: begin
                scl_n = quarter_n[1];
                oe_n  = 1'b0;                   // Codec owns SDA
            end
            codec_pkg::BIT_STOP: begin
                scl_n = quarter_n[1];
                sda_n = (quarter_n == 2'd3);    // Rises with SCL high
            end
            default: begin
                scl_n = 1'b1;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r   <= codec_pkg::BIT_IDLE;
            qcnt_r    <= '0;
            quarter_r <= 2'd0;
            bit_r     <= 3'd0;
            byte_r    <= 2'd0;
            nack_r    <= 1'b0;
            done_r    <= 1'b0;
            scl_r     <= 1'b1;
            sda_r     <= 1'b1;
            oe_r      <= 1'b1;
        end else begin
            state_r   <= state_n;
            qcnt_r    <= qcnt_n;
            quarter_r <= quarter_n;
            bit_r     <= bit_n;
            byte_r    <= byte_n;
            nack_r    <= nack_n;
            done_r    <= done_n;
            scl_r     <= scl_n;
            sda_r     <= sda_n;
            oe_r      <= oe_n;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_n;
    end

endmodule

// File: logic/codec_reg_rom.sv
`timescale 1ns/100ps
`include "codec_cfg.svh"

module codec_reg_rom #(
    parameter int IDX_W = $clog2(`CFG_NUM_REGS)
) (
    input  logic [IDX_W-1:0]        i_index,
    output codec_pkg::reg_write_t   o_write
);

    // Fixed codec bring-up sequence
    always_comb begin
        case (i_index)
            IDX_W'(0): begin
                o_write = '{reg_addr: 7'h0F, reg_data: 9'h000};     // Reset
            end
            IDX_W'(1): begin
                o_write = '{reg_addr: 7'h04, reg_data: 9'h015};     // Analogue path
            end
            IDX_W'(2): begin
                o_write = '{reg_addr: 7'h05, reg_data: 9'h000};     // Digital path
            end
            IDX_W'(3): begin
                o_write = '{reg_addr: 7'h06, reg_data: 9'h000};     // Power down
            end
            IDX_W'(4): begin
                o_write = '{reg_addr: 7'h07, reg_data: 9'h042};     // Interface format
            end
            IDX_W'(5): begin
                o_write = '{reg_addr: 7'h08, reg_data: 9'h019};     // Sampling control
            end
            default: begin
                // Active control, also for anything past the end
                o_write = '{reg_addr: 7'h09, reg_data: 9'h001};
            end
        endcase
    end

endmodule

// File: logic/codec_pkg.sv
package codec_pkg;

    // Payload of one codec register write
    typedef struct packed {
        logic [6:0] reg_addr;
        logic [8:0] reg_data;   // Bit 8 rides in the address byte
    } reg_write_t;

    // Sequencer status levels
    typedef struct packed {
        logic finished;
        logic error;
    } init_status_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LAUNCH,     // Waiting to pulse go
        SEQ_WAIT,       // Frame on the bus
        SEQ_DONE
    } seq_state_e;

    // Bit-level engine states
    typedef enum logic [2:0] {
        BIT_IDLE,
        BIT_START,
        BIT_DATA,
        BIT_ACK,
        BIT_STOP,
        BIT_DONE
    } bit_state_e;

endpackage

// File: include/codec_cfg.svh
`ifndef CODEC_CFG_SVH
`define CODEC_CFG_SVH

// Clock cycles per quarter of an SCL bit, at least 1
// One bit period is four quarters
`define CFG_I2C_QTR 4

// 7-bit I2C address of the codec
// Goes out in front of the write bit
`define CFG_DEV_ADDR 7'h1A

// Entries in the init table
// Index width is derived with $clog2 where needed
`define CFG_NUM_REGS 7

`endif
